// ==== project.f ====
+incdir+rtl
rtl/controlPkg.sv
rtl/instructionDecoder.sv
rtl/controlSequencer.sv
rtl/controlWordTable.sv
rtl/controlUnit.sv
testbench/controlUnitTb.sv

// ==== Bender.yml ====
package:
  name: control_unit

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/controlPkg.sv
      - rtl/instructionDecoder.sv
      - rtl/controlSequencer.sv
      - rtl/controlWordTable.sv
      - rtl/controlUnit.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/controlUnitTb.sv

// ==== testbench/controlUnitTb.sv ====
`include "control_config.svh"

module controlUnitTb;

    timeunit 1ns;
    timeprecision 1ps;

    import controlPkg::*;

    logic         clock;
    logic         reset;
    instrWord_t   instruction;
    controlWord_t control;
    logic         resetOut;

    phase_e       expectedPhase;        // Phase the current instruction should dispatch to.
    phase_e       modelPhase;
    int           modelStep;
    controlWord_t modelControl;
    logic         modelResetOut;
    bit           resetSeen = 1'b0;
    bit           checkOn = 1'b0;
    int           cycle = 0;
    int           lastPc;
    integer       seed = 32'h5a75958a;
    string        testName;
    int           testErrors;
    int           testsRun = 0;
    int           testsFailed = 0;
    int           totalErrors = 0;

    controlUnit controlUnit_inst (
        .clock       (clock),
        .reset       (reset),
        .instruction (instruction),
        .control     (control),
        .resetOut    (resetOut)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) cycle <= cycle + 1;

    // ****************************************
    // Reference sequence model
    // ****************************************
    function automatic int phaseLength(phase_e ph);
        if (ph == phaseSll)
            return 3;
        if (ph == phaseSlt)
            return 1;
        return 2;
    endfunction

    function automatic controlWord_t expectedWord(phase_e ph, int st);
        controlWord_t w;
        w = '0;
        case (ph)
            phaseFetch: begin
                if (st <= 3) begin
                    w.aluOp   = `ALU_ADD;                   // PC plus four.
                    w.srcBSel = `SRCB_FOUR;
                    w.pcWrite = (st == 3);
                    w.irWrite = (st == 3);
                end
                w.aWrite = (st == 4);
                w.bWrite = (st == 4);
            end
            phaseAdd, phaseSub, phaseAnd: begin
                w.aluOp       = (ph == phaseAdd) ? `ALU_ADD :
                                (ph == phaseSub) ? `ALU_SUB : `ALU_AND;
                w.aluOutWrite = 1'b1;
                w.srcASel     = 1'b1;
                w.regWrite    = (st == 1);
                w.regDestSel  = (st == 1) ? 2'd1 : 2'd0;
            end
            phaseAddi: begin
                w.srcASel     = 1'b1;
                w.aluOp       = (st == 0) ? `ALU_SUB : `ALU_ADD;
                w.aluOutWrite = (st == 0);
                w.srcBSel     = (st == 0) ? `SRCB_IMM : 2'd0;
                w.regWrite    = (st == 1);
            end
            phaseSll: begin
                w.regDestSel  = 2'd1;
                w.memToRegSel = `MEMTOREG_SHIFT;
                w.shiftAmtSel = (st == 0);
                w.shiftSrcSel = (st == 0);
                w.shiftOp     = (st == 0) ? `SHIFT_LOAD : `SHIFT_LEFT;
                w.regWrite    = (st == 2);
            end
            phaseSlt: begin
                w.regWrite    = 1'b1;
                w.aluOp       = `ALU_SLT;
                w.srcASel     = 1'b1;
                w.regDestSel  = 2'd1;
                w.memToRegSel = `MEMTOREG_SLT;
            end
            default: begin
                w = '0;
            end
        endcase
        return w;
    endfunction

    always @(posedge clock) begin
        resetSeen <= reset;
        if (reset) begin
            modelControl  <= '0;
            modelPhase    <= resetSeen ? phaseFetch : phaseHalt;
            modelStep     <= 0;
            modelResetOut <= !resetSeen;
        end else begin
            modelControl <= expectedWord(modelPhase, modelStep);
            if (modelPhase == phaseFetch && modelStep == 5) begin
                modelPhase    <= expectedPhase;         // Dispatch.
                modelStep     <= 0;
                modelResetOut <= (expectedPhase == phaseHalt);
            end else if (modelPhase != phaseFetch && modelPhase != phaseHalt &&
                         modelStep == phaseLength(modelPhase) - 1) begin
                modelPhase <= phaseFetch;
                modelStep  <= 0;
            end else if (modelPhase != phaseHalt) begin
                modelStep <= modelStep + 1;
            end
        end
    end

    always @(negedge clock) begin
        if (checkOn) begin
            assert (control == modelControl) else begin
                $display("Fail %s: control expected %h actual %h", testName, modelControl,
                         control);
                testErrors++;
            end
            assert (resetOut == modelResetOut) else begin
                $display("Fail %s: resetOut expected %b actual %b", testName, modelResetOut,
                         resetOut);
                testErrors++;
            end
        end
    end

    // ****************************************
    // Stimulus helpers
    // ****************************************
    function automatic instrWord_t rWord(logic [5:0] funct);
        instrWord_t w;
        w = $random(seed);                              // Random register fields.
        w.rType.opcode = `OPCODE_RTYPE;
        w.rType.funct  = funct;
        return w;
    endfunction

    function automatic instrWord_t iWord(logic [5:0] opcode);
        instrWord_t w;
        w = $random(seed);
        w.iType.opcode = opcode;
        return w;
    endfunction

    task automatic startTest(string name);
        testName   = name;
        testErrors = 0;
    endtask

    task automatic finishTest();
        testsRun++;
        totalErrors += testErrors;
        if (testErrors != 0)
            testsFailed++;
        $display("Test %s finished with %0d errors", testName, testErrors);
    endtask

    task automatic driveInstruction(instrWord_t instr, phase_e phase);
        @(posedge clock);
        instruction   <= instr;
        expectedPhase <= phase;
    endtask

    task automatic waitForPcWrite(output int at);
        int waited;
        waited = 0;
        at = -1;
        while (at < 0 && waited < 40) begin
            @(negedge clock);
            waited++;
            if (control.pcWrite)
                at = cycle;
        end
        if (at < 0) begin
            $display("Timeout in %s: pcWrite did not rise within 40 cycles", testName);
            testErrors++;
        end
    endtask

    // Called just after a pcWrite, so the word is stable before dispatch.
    task automatic runInstruction(instrWord_t instr, phase_e phase, int period);
        int at;
        driveInstruction(instr, phase);
        waitForPcWrite(at);
        assert (at - lastPc == period) else begin
            $display("Fail %s: period expected %0d actual %0d", testName, period, at - lastPc);
            testErrors++;
        end
        lastPc = at;
    endtask

    // ****************************************
    // Test sequence
    // ****************************************
    initial begin
        int i;
        int pick;
        int waited;
        reset         = 1'b1;
        instruction   = '0;
        expectedPhase = phaseSll;                       // All-zero word decodes as sll.
        repeat (16) @(posedge clock);
        reset <= 1'b0;

        startTest("reset");
        @(negedge clock);
        assert (control == '0 && resetOut == 1'b0) else begin
            $display("Fail reset: control/resetOut expected 0/0 actual %h/%b", control, resetOut);
            testErrors++;
        end
        checkOn = 1'b1;
        finishTest();

        startTest("arith");
        waitForPcWrite(lastPc);
        for (i = 0; i < 12; i++) begin
            pick = $unsigned($random(seed)) % 3;
            if (pick == 0)
                runInstruction(rWord(`FUNCT_ADD), phaseAdd, 8);
            else if (pick == 1)
                runInstruction(rWord(`FUNCT_SUB), phaseSub, 8);
            else
                runInstruction(rWord(`FUNCT_AND), phaseAnd, 8);
        end
        finishTest();

        startTest("addiSlt");
        runInstruction(iWord(`OPCODE_ADDI), phaseAddi, 8);
        runInstruction(rWord(`FUNCT_SLT), phaseSlt, 7);
        finishTest();

        startTest("sll");
        runInstruction(rWord(`FUNCT_SLL), phaseSll, 9);
        runInstruction(rWord(`FUNCT_SLL), phaseSll, 9);
        finishTest();

        startTest("unknown");
        runInstruction(iWord(6'b000100), phaseFetch, 6);
        runInstruction(rWord(6'b100101), phaseFetch, 6);
        finishTest();

        startTest("halt");
        driveInstruction(iWord(`OPCODE_HALT), phaseHalt);
        waited = 0;
        while (resetOut !== 1'b1 && waited < 20) begin
            @(negedge clock);
            waited++;
        end
        if (resetOut !== 1'b1) begin
            $display("Timeout in halt: resetOut did not rise within 20 cycles");
            testErrors++;
        end
        repeat (10) @(posedge clock);                   // Outputs stay idle while halted.
        reset <= 1'b1;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        waitForPcWrite(lastPc);
        runInstruction(rWord(`FUNCT_ADD), phaseAdd, 8);
        @(posedge clock);
        finishTest();

        checkOn = 1'b0;
        $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, totalErrors);
        if (testsFailed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/controlUnit.sv ====
module controlUnit (
    input  logic                     clock,
    input  logic                     reset,
    input  controlPkg::instrWord_t   instruction,
    output controlPkg::controlWord_t control,
    output logic                     resetOut
);

    import controlPkg::*;

    instrClass_e instrClass;
    seqPoint_t   point;         // Current phase and step.

    instructionDecoder instructionDecoder_inst (
        .instruction (instruction),
        .instrClass  (instrClass)
    );

    controlSequencer controlSequencer_inst (
        .clock      (clock),
        .reset      (reset),
        .instrClass (instrClass),
        .point      (point),
        .resetOut   (resetOut)
    );

    controlWordTable controlWordTable_inst (
        .clock   (clock),
        .reset   (reset),
        .point   (point),
        .control (control)
    );

endmodule

// ==== rtl/controlWordTable.sv ====
`include "control_config.svh"

module controlWordTable (
    input  logic                     clock,
    input  logic                     reset,
    input  controlPkg::seqPoint_t    point,
    output controlPkg::controlWord_t control
);

    import controlPkg::*;

    localparam logic [`STEP_BITS-1:0] irLoadStep  = `STEP_BITS'(3);
    localparam logic [`STEP_BITS-1:0] regReadStep = `STEP_BITS'(4);

    controlWord_t word;

    // ALU code of the two-step R-type arithmetic phases.
    function automatic logic [2:0] arithAluOp(phase_e phase);
        case (phase)
            phaseSub: return `ALU_SUB;
            phaseAnd: return `ALU_AND;
            default:  return `ALU_ADD;
        endcase
    endfunction

    // ****************************************
    // Sequence point to control word
    // ****************************************
    always_comb begin
        word = '0;
        case (point.phase)
            phaseFetch: begin
                if (point.step <= irLoadStep) begin
                    word.aluOp   = `ALU_ADD;        // PC plus four.
                    word.srcBSel = `SRCB_FOUR;
                end
                if (point.step == irLoadStep) begin
                    word.pcWrite = 1'b1;
                    word.irWrite = 1'b1;
                end
                if (point.step == regReadStep) begin
                    word.aluOp  = `ALU_LOAD;
                    word.aWrite = 1'b1;             // Latch both source registers.
                    word.bWrite = 1'b1;
                end
            end
            phaseAdd, phaseSub, phaseAnd: begin
                word.aluOutWrite = 1'b1;
                word.srcASel     = 1'b1;
                word.aluOp       = arithAluOp(point.phase);
                if (point.step == `STEP_BITS'(1)) begin
                    word.regWrite   = 1'b1;
                    word.regDestSel = 2'd1;         // Write to rd.
                end
            end
            phaseAddi: begin
                word.srcASel = 1'b1;
                if (point.step == '0) begin
                    word.aluOp       = `ALU_SUB;
                    word.aluOutWrite = 1'b1;
                    word.srcBSel     = `SRCB_IMM;
                end else begin
                    word.aluOp      = `ALU_ADD;
                    word.regWrite   = 1'b1;
                    word.regDestSel = 2'd0;         // Write to rt.
                end
            end
            phaseSll: begin
                word.regDestSel  = 2'd1;
                word.memToRegSel = `MEMTOREG_SHIFT;
                if (point.step == '0) begin
                    word.shiftAmtSel = 1'b1;        // Load rt with shamt.
                    word.shiftSrcSel = 1'b1;
                    word.shiftOp     = `SHIFT_LOAD;
                end else begin
                    word.shiftOp = `SHIFT_LEFT;
                end
                if (point.step == `STEP_BITS'(2)) begin
                    word.regWrite = 1'b1;
                end
            end
            phaseSlt: begin
                word.regWrite    = 1'b1;
                word.aluOp       = `ALU_SLT;
                word.srcASel     = 1'b1;
                word.regDestSel  = 2'd1;
                word.memToRegSel = `MEMTOREG_SLT;
            end
            default: begin
                word = '0;                          // halt drives nothing
            end
        endcase
    end

    // ****************************************
    // Output register
    // ****************************************
    always_ff @(posedge clock) begin
        if (reset) begin
            control <= '0;
        end else begin
            control <= word;
        end
    end

endmodule

// ==== rtl/controlSequencer.sv ====
`include "control_config.svh"

module controlSequencer (
    input  logic                    clock,
    input  logic                    reset,
    input  controlPkg::instrClass_e instrClass,
    output controlPkg::seqPoint_t   point,
    output logic                    resetOut
);

    import controlPkg::*;

    seqPoint_t nextPoint;
    logic      resetHeld;       // Reset was high on the previous edge.

    // Phase that the dispatch step enters for each instruction class.
    function automatic phase_e dispatchPhase(instrClass_e cls);
        case (cls)
            classAdd:  return phaseAdd;
            classSub:  return phaseSub;
            classAnd:  return phaseAnd;
            classSll:  return phaseSll;
            classSlt:  return phaseSlt;
            classAddi: return phaseAddi;
            classHalt: return phaseHalt;
            default:   return phaseFetch;
        endcase
    endfunction

    // Index of the final step of each execution phase.
    function automatic logic [`STEP_BITS-1:0] lastStep(phase_e phase);
        case (phase)
            phaseSll: return `STEP_BITS'(2);
            phaseSlt: return `STEP_BITS'(0);
            default:  return `STEP_BITS'(1);
        endcase
    endfunction

    // ****************************************
    // Next sequence point
    // ****************************************
    always_comb begin
        nextPoint = point;
        case (point.phase)
            phaseFetch: begin
                if (point.step == `FETCH_LAST) begin
                    nextPoint.phase = dispatchPhase(instrClass);
                    nextPoint.step  = '0;
                end else begin
                    nextPoint.step = point.step + 1'b1;
                end
            end
            phaseHalt: begin
                nextPoint = point;                  // Only reset leaves halt.
            end
            default: begin
                if (point.step == lastStep(point.phase)) begin
                    nextPoint.phase = phaseFetch;
                    nextPoint.step  = '0;
                end else begin
                    nextPoint.step = point.step + 1'b1;
                end
            end
        endcase
    end

    // ****************************************
    // State registers and two-stage reset
    // ****************************************
    always_ff @(posedge clock) begin
        resetHeld <= reset;
        if (reset) begin
            if (!resetHeld) begin
                point.phase <= phaseHalt;           // First reset cycle parks in halt.
                point.step  <= '0;
                resetOut    <= 1'b1;
            end else begin
                point.phase <= phaseFetch;
                point.step  <= '0;
                resetOut    <= 1'b0;
            end
        end else begin
            point    <= nextPoint;
            resetOut <= (nextPoint.phase == phaseHalt);
        end
    end

endmodule

// ==== rtl/instructionDecoder.sv ====
`include "control_config.svh"

module instructionDecoder (
    input  controlPkg::instrWord_t  instruction,
    output controlPkg::instrClass_e instrClass
);

    import controlPkg::*;

    always_comb begin
        instrClass = classNone;
        case (instruction.iType.opcode)
            `OPCODE_RTYPE: begin
                case (instruction.rType.funct)
                    `FUNCT_ADD: begin
                        instrClass = classAdd;
                    end
                    `FUNCT_SUB: begin
                        instrClass = classSub;
                    end
                    `FUNCT_AND: begin
                        instrClass = classAnd;
                    end
                    `FUNCT_SLL: begin
                        instrClass = classSll;
                    end
                    `FUNCT_SLT: begin
                        instrClass = classSlt;
                    end
                    default: begin
                        instrClass = classNone;     // Unsupported R-type operation.
                    end
                endcase
            end
            `OPCODE_ADDI: begin
                instrClass = classAddi;
            end
            `OPCODE_HALT: begin
                instrClass = classHalt;
            end
            default: begin
                instrClass = classNone;
            end
        endcase
    end

endmodule

// ==== rtl/controlPkg.sv ====
`include "control_config.svh"

package controlPkg;

    // ****************************************
    // Instruction word, two decodings
    // ****************************************
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [5:0]  funct;     // Selects the operation when opcode is R-type.
    } rTypeWord_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] immediate;
    } iTypeWord_t;

    typedef union packed {
        rTypeWord_t rType;
        iTypeWord_t iType;
    } instrWord_t;

    typedef enum logic [2:0] {
        classAdd,
        classSub,
        classAnd,
        classSll,
        classSlt,
        classAddi,
        classHalt,
        classNone           // Unknown opcode or funct.
    } instrClass_e;

    typedef enum logic [2:0] {
        phaseFetch,
        phaseAdd,
        phaseSub,
        phaseAnd,
        phaseSll,
        phaseSlt,
        phaseAddi,
        phaseHalt
    } phase_e;

    typedef struct packed {
        phase_e                 phase;
        logic [`STEP_BITS-1:0]  step;
    } seqPoint_t;

    // ****************************************
    // Datapath control word
    // ****************************************
    typedef struct packed {
        logic       pcWrite;
        logic       memReadWrite;
        logic       irWrite;
        logic       regWrite;
        logic       aWrite;
        logic       bWrite;
        logic       aluOutWrite;
        logic [2:0] aluOp;
        logic       srcASel;
        logic [1:0] srcBSel;
        logic [1:0] regDestSel;
        logic [3:0] memToRegSel;
        logic       shiftAmtSel;
        logic       shiftSrcSel;
        logic [2:0] shiftOp;
    } controlWord_t;

endpackage

// ==== rtl/control_config.svh ====
`ifndef CONTROL_CONFIG_SVH
`define CONTROL_CONFIG_SVH

// ****************************************
// Opcodes and funct codes
// ****************************************
`define OPCODE_RTYPE    6'b000000
`define OPCODE_ADDI     6'b001000
`define OPCODE_HALT     6'b111111

`define FUNCT_ADD       6'b100000
`define FUNCT_SUB       6'b100010
`define FUNCT_AND       6'b100100
`define FUNCT_SLL       6'b000000
`define FUNCT_SLT       6'b101010

// ****************************************
// Datapath operation and selector codes
// ****************************************
`define ALU_LOAD        3'd0
`define ALU_ADD         3'd1
`define ALU_SUB         3'd2
`define ALU_AND         3'd3
`define ALU_SLT         3'd7

`define SHIFT_LOAD      3'd1
`define SHIFT_LEFT      3'd2

`define MEMTOREG_SHIFT  4'd8
`define MEMTOREG_SLT    4'd4

`define SRCB_FOUR       2'd1
`define SRCB_IMM        2'd2

`define STEP_BITS       3
`define FETCH_LAST      3'd5    // Dispatch step of the fetch phase.

`endif
